// ==== hw/snowbro2_macros.svh ====
`ifndef SNOWBRO2_MACROS_SVH
`define SNOWBRO2_MACROS_SVH

// main cpu memory map, byte addresses
`define ROM_TOP      24'h07FFFF
`define RAM_BASE_HI  8'h10
`define GCU_BASE_HI  4'h3
`define PAL_BASE_HI  4'h4
`define IO_BASE_HI   12'h700

// io page offsets
`define IO_JMPR      12'h000
`define IO_DSWA      12'h004
`define IO_DSWB      12'h008
`define IO_IN1       12'h00C
`define IO_IN2       12'h010
`define IO_SYS       12'h01C

// gp9001 register offsets
`define GCU_PTR      4'h0
`define GCU_RAM_H    4'h4
`define GCU_RAM_L    4'h6
`define GCU_SEL      4'h8
`define GCU_REG      4'hC

`define RAM_AW       15   // 64kB work ram, in words
`define PAL_AW       11   // 4kB palette, in words
`define CEN_DIV      6    // 96 MHz down to 16 MHz

`endif

// ==== hw/snowbro2_pkg.sv ====
`default_nettype none

package snowbro2_pkg;

    // one 68k-style bus request, strobes active low
    typedef struct packed {
        logic        as_n;
        logic        rw;       // 1 = read
        logic        uds_n;
        logic        lds_n;
        logic [23:1] addr;     // word address
        logic [15:0] wdata;
    } bus_req_t;

    // registered region selects, at most one high
    typedef struct packed {
        logic rom;
        logic ram;
        logic pal;
        logic gcu;
        logic io;
    } region_sel_t;

    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic write_ram;
        logic read_ram_h;
        logic read_ram_l;
        logic set_ram_ptr;
    } gcu_op_t;

    // cabinet inputs, joysticks and buttons active high
    typedef struct packed {
        logic [9:0] joy1;
        logic [9:0] joy2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic       test;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
        logic [7:0] dipsw_c;
    } cab_in_t;

endpackage

`default_nettype wire

// ==== hw/bus_arbiter.sv ====
`default_nettype none
`timescale 1ns/10ps

module bus_arbiter import snowbro2_pkg::*; (
    input  wire logic     clk96,
    input  wire logic     reset96,
    input  wire logic     cen16b,
    input  wire bus_req_t cpu_req,
    input  wire bus_req_t ext_req,
    input  wire logic     br,        // external master wants the bus
    input  wire logic     dtack_n,
    output logic          bus_ack,
    output bus_req_t      gnt_req
);

    logic owner_idle;

    // owner has released AS and its DTACK is retired
    assign owner_idle = gnt_req.as_n & dtack_n;

    // grant follows br, but only between cycles of the current owner
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            bus_ack <= 1'b0;
        end else if (cen16b && owner_idle) begin
            bus_ack <= br;
        end
    end

    // owner's request onto the shared bus
    assign gnt_req = bus_ack ? ext_req : cpu_req;

    // a hand-over never cuts into a running cycle
    a_ack_between_cycles: assert property (
        @(posedge clk96) disable iff (reset96)
        $changed(bus_ack) |-> $past(gnt_req.as_n)
    );

endmodule

`default_nettype wire

// ==== hw/addr_decoder.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "snowbro2_macros.svh"

module addr_decoder import snowbro2_pkg::*; (
    input  wire logic     clk96,
    input  wire logic     reset96,
    input  wire bus_req_t gnt_req,
    output region_sel_t   sel,
    output logic [18:0]   rom_addr    // rom word address
);

    logic [23:0] byte_addr;

    assign byte_addr = {gnt_req.addr, 1'b0};    // easier to match the memory map

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            sel <= '0;
        end else if (!gnt_req.as_n) begin
            sel.rom <= byte_addr <= `ROM_TOP;                 // 000000-07FFFF
            sel.ram <= byte_addr[23:16] == `RAM_BASE_HI;      // 100000-10FFFF
            sel.gcu <= byte_addr[23:20] == `GCU_BASE_HI;      // 300000-30000D
            sel.pal <= byte_addr[23:20] == `PAL_BASE_HI;      // 400000-400FFF
            sel.io  <= byte_addr[23:12] == `IO_BASE_HI;       // 700000-700FFF
        end else begin
            sel <= '0;
        end
    end

    // rom address goes out together with the select
    always_ff @(posedge clk96) begin
        if (!gnt_req.as_n) begin
            rom_addr <= gnt_req.addr[19:1];
        end
    end

    a_sel_onehot: assert property (
        @(posedge clk96) disable iff (reset96)
        $onehot0(sel)
    );

endmodule

`default_nettype wire

// ==== hw/dtack_gen.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "snowbro2_macros.svh"

module dtack_gen import snowbro2_pkg::*; (
    input  wire logic        clk96,
    input  wire logic        reset96,
    input  wire logic        as_n,
    input  wire region_sel_t sel,
    input  wire logic        rom_ok,
    input  wire logic        gp9001_ack,
    output logic             cen16,
    output logic             cen16b,
    output logic             dtack_n
);

    localparam int DIV = `CEN_DIV;

    logic [2:0] div_cnt;
    logic [1:0] as_cnt;     // cycles since AS fell, saturates at 3
    logic       busy;
    logic       dtack_ok;

    // cpu clock enables, cen16b half a cpu clock after cen16
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            div_cnt <= '0;
            cen16   <= 1'b0;
            cen16b  <= 1'b0;
        end else begin
            div_cnt <= (div_cnt == 3'(DIV - 1)) ? 3'd0 : div_cnt + 3'd1;
            cen16   <= div_cnt == 3'd0;
            cen16b  <= div_cnt == 3'(DIV / 2);
        end
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            as_cnt <= '0;
        end else if (as_n) begin
            as_cnt <= '0;
        end else if (as_cnt != 2'd3) begin
            as_cnt <= as_cnt + 2'd1;
        end
    end

    // rom and gp9001 hold the cycle off until they answer
    assign busy     = (sel.rom & ~rom_ok) | (sel.gcu & ~gp9001_ack);
    assign dtack_ok = cen16 & (as_cnt == 2'd3) & (|sel) & ~busy;

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            dtack_n <= 1'b1;
        end else if (as_n) begin
            dtack_n <= 1'b1;    // cycle over
        end else if (dtack_ok) begin
            dtack_n <= 1'b0;
        end
    end

    a_dtack_needs_sel: assert property (
        @(posedge clk96) disable iff (reset96)
        !dtack_n |-> |sel
    );

endmodule

`default_nettype wire

// ==== hw/ram16_dp.sv ====
`default_nettype none
`timescale 1ns/10ps

module ram16_dp #(
    parameter int AW = 10
) (
    input  wire logic          clk96,
    // port 0, bus side with byte lanes
    input  wire logic [AW-1:0] addr0,
    input  wire logic [15:0]   wdata0,
    input  wire logic [1:0]    we0,      // {upper, lower}
    output logic      [15:0]   q0,
    // port 1, read only
    input  wire logic [AW-1:0] addr1,
    output logic      [15:0]   q1
);

    logic [15:0] mem [0:(2**AW)-1];

    always_ff @(posedge clk96) begin
        if (we0[1]) begin
            mem[addr0][15:8] <= wdata0[15:8];
        end
        if (we0[0]) begin
            mem[addr0][7:0] <= wdata0[7:0];
        end
        q0 <= mem[addr0];
    end

    // one cycle read latency, same as port 0
    always_ff @(posedge clk96) begin
        q1 <= mem[addr1];
    end

endmodule

`default_nettype wire

// ==== hw/gcu_cmd.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "snowbro2_macros.svh"

module gcu_cmd import snowbro2_pkg::*; (
    input  wire logic     clk96,
    input  wire logic     reset96,
    input  wire bus_req_t gnt_req,
    input  wire logic     sel_gcu,
    input  wire logic     gp9001_ack,
    output gcu_op_t       gcu_op
);

    logic [3:0] gcu_off;

    assign gcu_off = {gnt_req.addr[3:1], 1'b0};    // byte offset in the gp9001 window

    // strobes are set for the whole access and dropped once the chip acks
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            gcu_op <= '0;
        end else if (sel_gcu) begin
            if (gnt_req.rw) begin
                case (gcu_off)
                    `GCU_RAM_H: gcu_op.read_ram_h <= 1'b1;
                    `GCU_RAM_L: gcu_op.read_ram_l <= 1'b1;
                    default: ;
                endcase
            end else begin
                case (gcu_off)
                    `GCU_PTR:   gcu_op.set_ram_ptr <= 1'b1;
                    `GCU_RAM_H,
                    `GCU_RAM_L: gcu_op.write_ram   <= 1'b1;   // either half
                    `GCU_SEL:   gcu_op.select_reg  <= 1'b1;
                    `GCU_REG:   gcu_op.write_reg   <= 1'b1;
                    default: ;
                endcase
            end
        end else if (gp9001_ack) begin
            gcu_op <= '0;
        end
    end

    // only one operation starts per access, no second strobe joins later
    a_single_op: assert property (
        @(posedge clk96) disable iff (reset96)
        $past(sel_gcu) && $past(sel_gcu, 2) |-> $stable(gcu_op)
    );

endmodule

`default_nettype wire

// ==== hw/io_ports.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "snowbro2_macros.svh"

module io_ports import snowbro2_pkg::*; (
    input  wire logic        clk96,
    input  wire logic        reset96,
    input  wire bus_req_t    gnt_req,
    input  wire region_sel_t sel,
    input  wire cab_in_t     cab,
    input  wire logic [8:0]  v,
    input  wire logic        hsync,
    input  wire logic        vsync,
    input  wire logic        fblank,
    input  wire logic [15:0] rom_data,
    input  wire logic [15:0] gp9001_dout,
    input  wire logic [15:0] ram_q,
    input  wire logic [15:0] pal_q,
    output logic      [15:0] din,
    output logic      [15:0] video_status
);

    logic [11:0] io_off;
    logic [7:0]  p1_byte;
    logic [7:0]  p2_byte;
    logic [7:0]  sys_byte;
    logic [15:0] rd_mux;

    assign io_off = {gnt_req.addr[11:1], 1'b0};

    // board inputs are active low
    assign p1_byte = {2'b00, ~cab.joy1[5], ~cab.joy1[4], ~cab.joy1[0],
                      ~cab.joy1[1], ~cab.joy1[2], ~cab.joy1[3]};
    assign p2_byte = {2'b00, ~cab.joy2[5], ~cab.joy2[4], ~cab.joy2[0],
                      ~cab.joy2[1], ~cab.joy2[2], ~cab.joy2[3]};
    assign sys_byte = {1'b0, ~cab.start[1], ~cab.start[0], ~cab.coin[1],
                       ~cab.coin[0], ~cab.test, 1'b0, ~cab.service};

    // vertical count reads as ff past line 255
    assign video_status = {hsync, vsync, 5'b11111, fblank,
                           (v < 9'd256) ? v[7:0] : 8'hFF};

    always_comb begin
        rd_mux = 16'h0000;
        if (gnt_req.rw) begin
            if (sel.rom) begin
                rd_mux = rom_data;
            end else if (sel.ram) begin
                rd_mux = ram_q;
            end else if (sel.pal) begin
                rd_mux = pal_q;
            end else if (sel.gcu) begin
                rd_mux = gp9001_dout;
            end else if (sel.io) begin
                case (io_off)
                    `IO_JMPR: rd_mux = {2{cab.dipsw_c}};
                    `IO_DSWA: rd_mux = {2{cab.dipsw_a}};
                    `IO_DSWB: rd_mux = {2{cab.dipsw_b}};
                    `IO_IN1:  rd_mux = {2{p1_byte}};
                    `IO_IN2:  rd_mux = {2{p2_byte}};
                    `IO_SYS:  rd_mux = {cab.dipsw_c, sys_byte};
                    default:  rd_mux = 16'h0000;
                endcase
            end
        end
    end

    // settles well before dtack goes low
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            din <= 16'h0000;
        end else begin
            din <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== hw/snowbro2_bus.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "snowbro2_macros.svh"

module snowbro2_bus import snowbro2_pkg::*; (
    input  wire logic        clk96,
    input  wire logic        reset96,
    // bus masters
    input  wire bus_req_t    cpu_req,
    input  wire bus_req_t    ext_req,
    input  wire logic        br,
    output logic             bus_ack,
    output logic [15:0]      din,
    output logic             dtack_n,
    output logic             cen16,
    output logic             cen16b,
    // program rom
    output logic             rom_cs,
    output logic [18:0]      rom_addr,
    input  wire logic        rom_ok,
    input  wire logic [15:0] rom_data,
    // gp9001
    output gcu_op_t          gcu_op,
    input  wire logic        gp9001_ack,
    input  wire logic [15:0] gp9001_dout,
    // cabinet and video
    input  wire cab_in_t     cab,
    input  wire logic [8:0]  v,
    input  wire logic        hsync,
    input  wire logic        vsync,
    input  wire logic        fblank,
    output logic [15:0]      video_status,
    input  wire logic [10:0] palram_addr,
    output logic [15:0]      palram_data
);

    bus_req_t    gnt_req;
    region_sel_t sel;
    logic [1:0]  ram_we;
    logic [1:0]  pal_we;
    logic [15:0] ram_q;
    logic [15:0] pal_q;

    assign rom_cs = sel.rom;
    assign ram_we = {2{sel.ram & ~gnt_req.rw}} & ~{gnt_req.uds_n, gnt_req.lds_n};
    assign pal_we = {2{sel.pal & ~gnt_req.rw}} & ~{gnt_req.uds_n, gnt_req.lds_n};

    bus_arbiter u_arbiter (
        .clk96   (clk96),
        .reset96 (reset96),
        .cen16b  (cen16b),
        .cpu_req (cpu_req),
        .ext_req (ext_req),
        .br      (br),
        .dtack_n (dtack_n),
        .bus_ack (bus_ack),
        .gnt_req (gnt_req)
    );

    addr_decoder u_decoder (
        .clk96    (clk96),
        .reset96  (reset96),
        .gnt_req  (gnt_req),
        .sel      (sel),
        .rom_addr (rom_addr)
    );

    dtack_gen u_dtack (
        .clk96      (clk96),
        .reset96    (reset96),
        .as_n       (gnt_req.as_n),
        .sel        (sel),
        .rom_ok     (rom_ok),
        .gp9001_ack (gp9001_ack),
        .cen16      (cen16),
        .cen16b     (cen16b),
        .dtack_n    (dtack_n)
    );

    // work ram 100000-10FFFF, bus port only
    ram16_dp #(.AW(`RAM_AW)) u_wram (
        .clk96  (clk96),
        .addr0  (gnt_req.addr[15:1]),
        .wdata0 (gnt_req.wdata),
        .we0    (ram_we),
        .q0     (ram_q),
        .addr1  ({`RAM_AW{1'b0}}),
        .q1     ()
    );

    // palette 400000-400FFF, port 1 feeds video
    ram16_dp #(.AW(`PAL_AW)) u_palram (
        .clk96  (clk96),
        .addr0  (gnt_req.addr[11:1]),
        .wdata0 (gnt_req.wdata),
        .we0    (pal_we),
        .q0     (pal_q),
        .addr1  (palram_addr),
        .q1     (palram_data)
    );

    gcu_cmd u_gcu_cmd (
        .clk96      (clk96),
        .reset96    (reset96),
        .gnt_req    (gnt_req),
        .sel_gcu    (sel.gcu),
        .gp9001_ack (gp9001_ack),
        .gcu_op     (gcu_op)
    );

    io_ports u_io (
        .clk96        (clk96),
        .reset96      (reset96),
        .gnt_req      (gnt_req),
        .sel          (sel),
        .cab          (cab),
        .v            (v),
        .hsync        (hsync),
        .vsync        (vsync),
        .fblank       (fblank),
        .rom_data     (rom_data),
        .gp9001_dout  (gp9001_dout),
        .ram_q        (ram_q),
        .pal_q        (pal_q),
        .din          (din),
        .video_status (video_status)
    );

endmodule

`default_nettype wire

// ==== dv/tb_snowbro2_bus.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "snowbro2_macros.svh"

module tb_snowbro2_bus import snowbro2_pkg::*; ();

    localparam int TIMEOUT = 200;     // cycles per wait
    localparam bus_req_t IDLE_REQ = {4'b1111, 23'h0, 16'h0};

    // one bus access of the stimulus table
    typedef struct packed {
        logic        ext;     // 1 = external master
        logic [23:0] addr;    // byte address
        logic        rw;
        logic [1:0]  lanes;   // {upper, lower}
        logic [15:0] wdata;
        logic [15:0] exp;     // expected read data
        gcu_op_t     op;      // expected gp9001 strobe
        logic [2:0]  delay;   // rom or gp9001 answer delay
    } row_t;

    logic        clk96;
    logic        reset96;
    bus_req_t    cpu_req;
    bus_req_t    ext_req;
    logic        br;
    logic        bus_ack;
    logic [15:0] din;
    logic        dtack_n;
    logic        cen16;
    logic        cen16b;
    logic        rom_cs;
    logic [18:0] rom_addr;
    logic        rom_ok = 1'b0;
    logic [15:0] rom_data = 16'hDEAD;
    gcu_op_t     gcu_op;
    logic        gp9001_ack = 1'b0;
    logic [15:0] gp9001_dout;
    cab_in_t     cab;
    logic [8:0]  v;
    logic        hsync;
    logic        vsync;
    logic        fblank;
    logic [15:0] video_status;
    logic [10:0] palram_addr;
    logic [15:0] palram_data;

    logic [15:0] lfsr = 16'd21;
    logic [2:0]  dev_delay;
    logic [3:0]  rom_cnt;
    logic [3:0]  gcu_cnt;
    row_t        rows [$];
    int          next_row;
    logic [15:0] ram_ref [0:(1 << `RAM_AW) - 1];   // lane-merging work ram model
    logic [15:0] pal_ref [0:(1 << `PAL_AW) - 1];
    logic [14:0] ram_w [0:3];
    logic [10:0] pal_w [0:5];
    int          checks;
    int          errors;
    int          test_err0;
    int          bad_tests;

    snowbro2_bus UUT (.*);

    always #2 clk96 = ~clk96;

    // rom holds junk data until it answers a few cycles after the select
    always @(negedge clk96) begin
        if (!rom_cs) begin
            rom_cnt  <= '0;
            rom_ok   <= 1'b0;
            rom_data <= 16'hDEAD;
        end else if (rom_cnt >= {1'b0, dev_delay}) begin
            rom_ok   <= 1'b1;
            rom_data <= rom_word(rom_addr);
        end else begin
            rom_cnt <= rom_cnt + 4'd1;
        end
    end

    // gp9001 acks a raised strobe and holds ack until it drops
    always @(negedge clk96) begin
        if (gcu_op == '0) begin
            gcu_cnt    <= '0;
            gp9001_ack <= 1'b0;
        end else if (gcu_cnt >= {1'b0, dev_delay}) begin
            gp9001_ack <= 1'b1;
        end else begin
            gcu_cnt <= gcu_cnt + 4'd1;
        end
    end

    // fibonacci lfsr with taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [15:0] rom_word(input logic [18:0] a);
        return a[15:0] ^ {a[18:16], a[18:16], a[18:16], a[18:16], a[18:16], 1'b1};
    endfunction

    function automatic logic [15:0] lane_merge(input logic [15:0] old, input logic [15:0] nw,
                                               input logic [1:0] lanes);
        return {lanes[1] ? nw[15:8] : old[15:8], lanes[0] ? nw[7:0] : old[7:0]};
    endfunction

    function automatic logic [7:0] player_byte(input logic [9:0] joy);
        return {2'b00, ~{joy[5], joy[4], joy[0], joy[1], joy[2], joy[3]}};
    endfunction

    function automatic gcu_op_t expected_op(input logic rw, input logic [3:0] off);
        gcu_op_t op;
        op = '0;
        if (rw) begin
            op.read_ram_h  = off == 4'h4;
            op.read_ram_l  = off == 4'h6;
        end else begin
            op.set_ram_ptr = off == 4'h0;
            op.write_ram   = (off == 4'h4) || (off == 4'h6);
            op.select_reg  = off == 4'h8;
            op.write_reg   = off == 4'hC;
        end
        return op;
    endfunction

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [18:0] got,
                              input logic [18:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ops(input string name, input gcu_op_t got, input gcu_op_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic wait_failed(input string what);
        errors++;
        $display("timeout at %0t ns: %s never came", $time, what);
    endtask

    task automatic add_row(input logic ext, input logic [23:0] addr, input logic rw,
                           input logic [1:0] lanes, input logic [15:0] wdata,
                           input logic [15:0] exp, input gcu_op_t op);
        row_t r;
        r.ext   = ext;
        r.addr  = addr;
        r.rw    = rw;
        r.lanes = lanes;
        r.wdata = wdata;
        r.exp   = exp;
        r.op    = op;
        r.delay = rand_bits(3);
        rows.push_back(r);
    endtask

    task automatic ram_write(input logic ext, input logic [14:0] w, input logic [1:0] lanes);
        logic [15:0] d;
        d          = rand_bits(16);
        ram_ref[w] = lane_merge(ram_ref[w], d, lanes);
        add_row(ext, {`RAM_BASE_HI, w, 1'b0}, 1'b0, lanes, d, 16'h0, '0);
    endtask

    task automatic pal_write(input logic [10:0] w, input logic [1:0] lanes);
        logic [15:0] d;
        d          = rand_bits(16);
        pal_ref[w] = lane_merge(pal_ref[w], d, lanes);
        add_row(1'b0, {`PAL_BASE_HI, 8'h00, w, 1'b0}, 1'b0, lanes, d, 16'h0, '0);
    endtask

    task automatic start_cycle(input row_t r);
        bus_req_t q;
        q.as_n  = 1'b0;
        q.rw    = r.rw;
        q.uds_n = ~r.lanes[1];
        q.lds_n = ~r.lanes[0];
        q.addr  = r.addr[23:1];
        q.wdata = r.wdata;
        @(negedge clk96);
        dev_delay = r.delay;
        if (r.ext) begin
            ext_req = q;
        end else begin
            cpu_req = q;
        end
    endtask

    task automatic finish_cycle(input row_t r);
        int      n;
        logic    ack_seen;
        logic    is_rom;
        logic    is_gcu;
        gcu_op_t op_at_ack;
        n         = 0;
        ack_seen  = 1'b0;
        op_at_ack = '0;
        is_rom    = r.rw && (r.addr <= `ROM_TOP);
        is_gcu    = r.addr[23:20] == `GCU_BASE_HI;
        do begin
            @(negedge clk96);
            n++;
            if (gp9001_ack && !ack_seen) begin
                ack_seen  = 1'b1;
                op_at_ack = gcu_op;    // strobe still up when the chip answers
            end
        end while (dtack_n && n < TIMEOUT);
        if (dtack_n) begin
            wait_failed("dtack_n low");
        end else begin
            if (r.rw) begin
                check_word("din", din, r.exp);
            end
            if (is_rom) begin
                check_bit("rom_cs", rom_cs, 1'b1);
                check_bit("rom_ok", rom_ok, 1'b1);
                check_addr("rom_addr", rom_addr, r.addr[19:1]);
            end
            if (is_gcu) begin
                check_ops("gcu_op at ack", op_at_ack, r.op);
            end
        end
        if (r.ext) begin
            ext_req = IDLE_REQ;
        end else begin
            cpu_req = IDLE_REQ;
        end
        n = 0;
        while (!dtack_n && n < TIMEOUT) begin
            @(negedge clk96);
            n++;
        end
        if (!dtack_n) begin
            wait_failed("dtack_n release");
        end
        if (is_gcu) begin
            n = 0;
            while (gcu_op != '0 && n < TIMEOUT) begin
                @(negedge clk96);
                n++;
            end
            check_ops("gcu_op after ack", gcu_op, '0);
        end
    endtask

    task automatic run_new_rows();
        while (next_row < rows.size()) begin
            start_cycle(rows[next_row]);
            finish_cycle(rows[next_row]);
            next_row++;
        end
    endtask

    task automatic wait_bus_ack(input logic level);
        int n;
        n = 0;
        while (bus_ack !== level && n < TIMEOUT) begin
            @(negedge clk96);
            n++;
        end
        if (bus_ack !== level) begin
            wait_failed("bus_ack change");
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == test_err0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - test_err0);
            bad_tests++;
        end
        test_err0 = errors;
    endtask

    task automatic test_reset();
        int n;
        int gap;
        check_bit("dtack_n", dtack_n, 1'b1);
        check_bit("bus_ack", bus_ack, 1'b0);
        check_bit("rom_cs", rom_cs, 1'b0);
        check_ops("gcu_op", gcu_op, '0);
        check_word("din", din, 16'h0000);
        n = 0;
        while (!cen16 && n < TIMEOUT) begin
            @(negedge clk96);
            n++;
        end
        for (int k = 0; k < 4; k++) begin
            gap = 0;
            do begin
                @(negedge clk96);
                gap++;
            end while (!cen16 && gap < TIMEOUT);
            check_word("cen16 period", 16'(gap), 16'd`CEN_DIV);
        end
        // second enable sits half a cpu clock behind the first
        gap = 0;
        do begin
            @(negedge clk96);
            gap++;
        end while (!cen16b && gap < TIMEOUT);
        check_word("cen16b after cen16", 16'(gap), 16'd3);
    endtask

    task automatic test_video_status();
        logic [8:0]  vv;
        logic [7:0]  vlow;
        logic [2:0]  sb;
        for (int k = 0; k < 6; k++) begin
            case (k)
                0: {vv, vlow} = {9'd0, 8'h00};
                1: {vv, vlow} = {9'd131, 8'h83};
                2: {vv, vlow} = {9'd255, 8'hFF};
                3: {vv, vlow} = {9'd256, 8'hFF};     // first line past the visible count
                4: {vv, vlow} = {9'd300, 8'hFF};
                default: {vv, vlow} = {9'd511, 8'hFF};
            endcase
            for (int s = 0; s < 8; s++) begin
                sb = 3'(s);
                @(negedge clk96);
                v      = vv;
                hsync  = sb[2];
                vsync  = sb[1];
                fblank = sb[0];
                @(negedge clk96);
                check_word("video_status", video_status,
                           {sb[2], sb[1], 5'b11111, sb[0], vlow});
            end
        end
    endtask

    task automatic test_arbitration();
        logic early;
        @(negedge clk96);
        br = 1'b1;
        wait_bus_ack(1'b1);
        check_bit("bus_ack", bus_ack, 1'b1);
        ram_write(1'b1, ram_w[3], 2'b11);
        ram_write(1'b1, ram_w[3], 2'b01);
        add_row(1'b1, {`RAM_BASE_HI, ram_w[3], 1'b0}, 1'b1, 2'b11, 16'h0, ram_ref[ram_w[3]], '0);
        add_row(1'b1, {`RAM_BASE_HI, ram_w[0], 1'b0}, 1'b1, 2'b11, 16'h0, ram_ref[ram_w[0]], '0);
        run_new_rows();
        // cpu read left pending while the external master owns the bus
        add_row(1'b0, {`RAM_BASE_HI, ram_w[3], 1'b0}, 1'b1, 2'b11, 16'h0, ram_ref[ram_w[3]], '0);
        start_cycle(rows[next_row]);
        early = 1'b0;
        repeat (30) begin
            @(negedge clk96);
            if (!dtack_n) begin
                early = 1'b1;
            end
        end
        check_bit("dtack_n low during grant", early, 1'b0);
        br = 1'b0;
        wait_bus_ack(1'b0);
        check_bit("bus_ack", bus_ack, 1'b0);
        finish_cycle(rows[next_row]);
        next_row++;
    endtask

    initial begin
        clk96       = 1'b0;
        reset96     = 1'b1;
        cpu_req     = IDLE_REQ;
        ext_req     = IDLE_REQ;
        br          = 1'b0;
        v           = 9'd0;
        hsync       = 1'b0;
        vsync       = 1'b0;
        fblank      = 1'b0;
        palram_addr = '0;
        dev_delay   = '0;
        next_row    = 0;
        checks      = 0;
        errors      = 0;
        test_err0   = 0;
        bad_tests   = 0;
        gp9001_dout = rand_bits(16);
        cab.joy1    = rand_bits(10);
        cab.joy2    = rand_bits(10);
        cab.start   = rand_bits(2);
        cab.coin    = rand_bits(2);
        cab.service = rand_bits(1);
        cab.test    = rand_bits(1);
        cab.dipsw_a = rand_bits(8);
        cab.dipsw_b = rand_bits(8);
        cab.dipsw_c = rand_bits(8);
        repeat (10) @(negedge clk96);
        reset96 = 1'b0;
        @(negedge clk96);
        test_reset();
        end_test(1, "reset state");

        for (int i = 0; i < 4; i++) begin
            ram_w[i] = rand_bits(15);
            ram_write(1'b0, ram_w[i], 2'b11);
        end
        ram_write(1'b0, ram_w[0], 2'b10);
        ram_write(1'b0, ram_w[1], 2'b01);
        ram_write(1'b0, ram_w[2], 2'b11);
        for (int i = 0; i < 4; i++) begin
            add_row(1'b0, {`RAM_BASE_HI, ram_w[i], 1'b0}, 1'b1, 2'b11, 16'h0,
                    ram_ref[ram_w[i]], '0);
        end
        run_new_rows();
        end_test(2, "work ram");

        for (int i = 0; i < 6; i++) begin
            pal_w[i] = rand_bits(11);
            pal_write(pal_w[i], 2'b11);
        end
        pal_write(pal_w[4], 2'b01);
        add_row(1'b0, {`PAL_BASE_HI, 8'h00, pal_w[4], 1'b0}, 1'b1, 2'b11, 16'h0,
                pal_ref[pal_w[4]], '0);
        run_new_rows();
        @(negedge clk96);
        palram_addr = pal_w[0];
        for (int i = 1; i <= 6; i++) begin
            @(negedge clk96);
            check_word("palram_data", palram_data, pal_ref[pal_w[i - 1]]);
            if (i < 6) begin
                palram_addr = pal_w[i];
            end
        end
        end_test(3, "palette ram");

        add_row(1'b0, {`IO_BASE_HI, `IO_IN1}, 1'b1, 2'b11, 16'h0, {2{player_byte(cab.joy1)}}, '0);
        add_row(1'b0, {`IO_BASE_HI, `IO_IN2}, 1'b1, 2'b11, 16'h0, {2{player_byte(cab.joy2)}}, '0);
        add_row(1'b0, {`IO_BASE_HI, `IO_DSWA}, 1'b1, 2'b11, 16'h0, {2{cab.dipsw_a}}, '0);
        add_row(1'b0, {`IO_BASE_HI, `IO_DSWB}, 1'b1, 2'b11, 16'h0, {2{cab.dipsw_b}}, '0);
        add_row(1'b0, {`IO_BASE_HI, `IO_JMPR}, 1'b1, 2'b11, 16'h0, {2{cab.dipsw_c}}, '0);
        add_row(1'b0, {`IO_BASE_HI, `IO_SYS}, 1'b1, 2'b11, 16'h0,
                {cab.dipsw_c, 1'b0, ~cab.start[1], ~cab.start[0], ~cab.coin[1],
                 ~cab.coin[0], ~cab.test, 1'b0, ~cab.service}, '0);
        add_row(1'b0, {`IO_BASE_HI, 12'h020}, 1'b1, 2'b11, 16'h0, 16'h0000, '0);
        run_new_rows();
        test_video_status();
        end_test(4, "io ports and video status");

        for (int i = 0; i < 3; i++) begin
            logic [17:0] rw_addr;
            rw_addr = rand_bits(18);
            add_row(1'b0, {5'h00, rw_addr, 1'b0}, 1'b1, 2'b11, 16'h0,
                    rom_word({1'b0, rw_addr}), '0);
        end
        add_row(1'b0, {`GCU_BASE_HI, 16'h0, `GCU_PTR}, 1'b0, 2'b11, rand_bits(16), 16'h0,
                expected_op(1'b0, 4'h0));
        add_row(1'b0, {`GCU_BASE_HI, 16'h0, `GCU_RAM_H}, 1'b0, 2'b11, rand_bits(16), 16'h0,
                expected_op(1'b0, 4'h4));
        add_row(1'b0, {`GCU_BASE_HI, 16'h0, `GCU_RAM_L}, 1'b0, 2'b11, rand_bits(16), 16'h0,
                expected_op(1'b0, 4'h6));
        add_row(1'b0, {`GCU_BASE_HI, 16'h0, `GCU_SEL}, 1'b0, 2'b11, rand_bits(16), 16'h0,
                expected_op(1'b0, 4'h8));
        add_row(1'b0, {`GCU_BASE_HI, 16'h0, `GCU_REG}, 1'b0, 2'b11, rand_bits(16), 16'h0,
                expected_op(1'b0, 4'hC));
        add_row(1'b0, {`GCU_BASE_HI, 16'h0, `GCU_RAM_H}, 1'b1, 2'b11, 16'h0, gp9001_dout,
                expected_op(1'b1, 4'h4));
        add_row(1'b0, {`GCU_BASE_HI, 16'h0, `GCU_RAM_L}, 1'b1, 2'b11, 16'h0, gp9001_dout,
                expected_op(1'b1, 4'h6));
        run_new_rows();
        end_test(5, "rom and gp9001");

        test_arbitration();
        end_test(6, "bus arbitration");

        $display("6 tests, %0d with errors, %0d checks, %0d errors", bad_tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/snowbro2_pkg.sv
hw/bus_arbiter.sv
hw/addr_decoder.sv
hw/dtack_gen.sv
hw/ram16_dp.sv
hw/gcu_cmd.sv
hw/io_ports.sv
hw/snowbro2_bus.sv
dv/tb_snowbro2_bus.sv

// ==== Bender.yml ====
package:
  name: snowbro2_bus

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/snowbro2_pkg.sv
      - hw/bus_arbiter.sv
      - hw/addr_decoder.sv
      - hw/dtack_gen.sv
      - hw/ram16_dp.sv
      - hw/gcu_cmd.sv
      - hw/io_ports.sv
      - hw/snowbro2_bus.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/tb_snowbro2_bus.sv
